// File: common/flash_if_pkg.sv
// flash controller side types, pulse fields must be one clock_rd2 tick wide
`default_nettype none

package flash_if_pkg;

	// flash data path is byte wide
	localparam int FLASH_BYTE_W = 8;

	// ==================================================
	// request toward the flash controller
	// ==================================================
	typedef struct packed {
		// one-tick pulses
		logic                    read;
		logic                    write;
		logic                    sector_erase;
		logic                    en4b_addr;
		logic                    wren;
		logic                    shift_bytes;
		// held level while a read is collecting
		logic                    rden;
		logic [FLASH_BYTE_W-1:0] datain;
		logic [31:0]             addr;
	} flash_req_t;

	// response from the flash controller
	typedef struct packed {
		logic [FLASH_BYTE_W-1:0] dataout;
		logic                    busy;
		logic                    data_valid;
		logic                    illegal_write;
		logic                    illegal_erase;
	} flash_rsp_t;

	// flash stores each byte msb/lsb swapped relative to the image file
	function automatic logic [FLASH_BYTE_W-1:0] bit_rev(input logic [FLASH_BYTE_W-1:0] b);
		return {<<{b}};
	endfunction

endpackage

`default_nettype wire

// File: common/host_reg_pkg.sv
// host register layout, opcodes are only valid in the low byte of the control word
`default_nettype none

package host_reg_pkg;

	// ==================================================
	// command opcodes, held as a level by the host
	// ==================================================
	// 0x00 is idle, the host returns here to abort or restart
	typedef enum logic [7:0] {
		FLASH_READ  = 8'h09,
		FLASH_WRITE = 8'h0A,
		FLASH_EN4B  = 8'h0B,
		FLASH_ERASE = 8'h0C,
		BUF_LOAD    = 8'h0D,
		BUSY_CLEAR  = 8'h0E
	} host_opcode_e;

	// decoded command levels, at most one high
	typedef struct packed {
		logic read;
		logic write;
		logic erase;
		logic en4b;
		logic load;
		logic busy_clear;
	} cmd_flags_t;

	// data word as seen during a buffer load
	typedef struct packed {
		logic [15:0] reserved;
		logic [7:0]  load_addr;
		logic [7:0]  load_byte;
	} load_view_t;

	// data word as seen during a flash read
	typedef struct packed {
		logic [23:0] reserved;
		logic [7:0]  last_index;
	} read_view_t;

	// one host word, meaning depends on the active command
	typedef union packed {
		load_view_t ld;
		read_view_t rd;
	} data_word_u;

	// status word, msb first
	typedef struct packed {
		logic [7:0]  staged_byte;
		logic [15:0] reserved;
		logic        load_en;
		logic        read_en;
		logic        busy_fe;
		logic        busy_re;
		logic        illegal_erase;
		logic        illegal_write;
		logic        data_valid;
		logic        busy;
	} status_t;

endpackage

`default_nettype wire

// File: hdl/byte_buffer.sv
// both ports read one tick after the address, port a reads the old byte on a write
`timescale 1ns/1ns
`default_nettype none

module byte_buffer #(
	parameter int ADDR_W = 8
) (
	input  wire logic                                   clock_rd2,
	input  wire logic [ADDR_W-1:0]                      a_addr,
	input  wire logic [flash_if_pkg::FLASH_BYTE_W-1:0]  a_din,
	input  wire logic                                   a_we,
	output logic [flash_if_pkg::FLASH_BYTE_W-1:0]       a_dout,
	input  wire logic [ADDR_W-1:0]                      b_addr,
	output logic [flash_if_pkg::FLASH_BYTE_W-1:0]       b_dout
);
	import flash_if_pkg::*;

	logic [FLASH_BYTE_W-1:0] mem [2**ADDR_W];

	// port a, write plus readback
	always_ff @(posedge clock_rd2) begin
		if (a_we) begin
			mem[a_addr] <= a_din;
		end
		a_dout <= mem[a_addr];
	end

	// port b, read only
	always_ff @(posedge clock_rd2) begin
		b_dout <= mem[b_addr];
	end

endmodule

`default_nettype wire

// File: hdl/flash_bridge_top.sv
// single clock bridge, no host acknowledge, flash controller lives outside this design
`timescale 1ns/1ns
`default_nettype none

module flash_bridge_top #(
	parameter int BUF_ADDR_W = 8,
	parameter int PAGE_BYTES = 128
) (
	input  wire logic                                     clock_rd2,
	input  wire logic                                     reset,
	input  wire logic [31:0]                              cntlr_word,
	input  wire logic [31:0]                              addr_word,
	input  wire logic [31:0]                              data_word,
	input  wire logic                                     host_we,
	output host_reg_pkg::status_t                         status_word,
	output logic [flash_if_pkg::FLASH_BYTE_W-1:0]         rd_byte,
	output flash_if_pkg::flash_req_t                      flash_req,
	input  wire flash_if_pkg::flash_rsp_t                 flash_rsp
);
	import host_reg_pkg::*;
	import flash_if_pkg::*;

	// ==================================================
	// internal wiring
	// ==================================================
	cmd_flags_t              cmds;
	flash_req_t              ctrl_req;
	logic [FLASH_BYTE_W-1:0] seq_datain;
	logic [FLASH_BYTE_W-1:0] staged_byte;
	logic                    shift_level;
	logic                    page_done;
	logic                    read_en;

	// decode, pulses, busy latches, status
	flash_control u_control (
		.clock_rd2   (clock_rd2),
		.reset       (reset),
		.cntlr_word  (cntlr_word),
		.addr_word   (addr_word),
		.flash_rsp   (flash_rsp),
		.shift_level (shift_level),
		.page_done   (page_done),
		.read_en     (read_en),
		.staged_byte (staged_byte),
		.cmds        (cmds),
		.flash_req   (ctrl_req),
		.status_word (status_word)
	);

	// returned bytes into the read buffer
	read_capture #(
		.BUF_ADDR_W (BUF_ADDR_W)
	) u_read (
		.clock_rd2 (clock_rd2),
		.reset     (reset),
		.cmds      (cmds),
		.data_word (data_word_u'(data_word)),
		.flash_rsp (flash_rsp),
		.host_addr (addr_word[BUF_ADDR_W-1:0]),
		.read_en   (read_en),
		.rd_byte   (rd_byte)
	);

	// staging buffer and page shift-out
	write_sequencer #(
		.BUF_ADDR_W (BUF_ADDR_W),
		.PAGE_BYTES (PAGE_BYTES)
	) u_write (
		.clock_rd2   (clock_rd2),
		.reset       (reset),
		.cmds        (cmds),
		.data_word   (data_word_u'(data_word)),
		.host_we     (host_we),
		.datain      (seq_datain),
		.shift_level (shift_level),
		.page_done   (page_done),
		.staged_byte (staged_byte)
	);

	// control side request, datain taken from the write sequencer
	assign flash_req = '{
		read:         ctrl_req.read,
		write:        ctrl_req.write,
		sector_erase: ctrl_req.sector_erase,
		en4b_addr:    ctrl_req.en4b_addr,
		wren:         ctrl_req.wren,
		shift_bytes:  ctrl_req.shift_bytes,
		rden:         ctrl_req.rden,
		datain:       seq_datain,
		addr:         ctrl_req.addr
	};

endmodule

`default_nettype wire

// File: hdl/flash_control.sv
// opcode reaches the decode 2 ticks late, busy edges stay latched until BUSY_CLEAR
`timescale 1ns/1ns
`default_nettype none

module flash_control (
	input  wire logic                                 clock_rd2,
	input  wire logic                                 reset,
	input  wire logic [31:0]                          cntlr_word,
	input  wire logic [31:0]                          addr_word,
	input  wire flash_if_pkg::flash_rsp_t             flash_rsp,
	input  wire logic                                 shift_level,
	input  wire logic                                 page_done,
	input  wire logic                                 read_en,
	input  wire logic [flash_if_pkg::FLASH_BYTE_W-1:0] staged_byte,
	output host_reg_pkg::cmd_flags_t                  cmds,
	output flash_if_pkg::flash_req_t                  flash_req,
	output host_reg_pkg::status_t                     status_word
);
	import host_reg_pkg::*;
	import flash_if_pkg::*;

	// bit positions in the pulse history
	localparam int P_WRITE = 3;
	localparam int P_READ  = 2;
	localparam int P_ERASE = 1;
	localparam int P_EN4B  = 0;

	logic [7:0]  op_q1;
	logic [7:0]  op_q2;
	logic [31:0] addr_q;
	logic [3:0]  lvl_src;
	logic [3:0]  lvl_q;
	logic [3:0]  lvl_qq;
	logic [3:0]  pulse;
	logic        busy_q;
	logic        busy_qq;
	logic        busy_re;
	logic        busy_fe;

	// ==================================================
	// opcode pipeline and decode
	// ==================================================
	always_ff @(posedge clock_rd2) begin
		if (reset) begin
			op_q1 <= '0;
			op_q2 <= '0;
		end else begin
			op_q1 <= cntlr_word[7:0];
			op_q2 <= op_q1;
		end
	end

	// address is payload, registered once
	always_ff @(posedge clock_rd2) begin
		addr_q <= addr_word;
	end

	always_comb begin
		cmds = '0;
		case (op_q2)
			FLASH_READ:  cmds.read = 1'b1;
			FLASH_WRITE: cmds.write = 1'b1;
			FLASH_EN4B:  cmds.en4b = 1'b1;
			FLASH_ERASE: cmds.erase = 1'b1;
			BUF_LOAD:    cmds.load = 1'b1;
			BUSY_CLEAR:  cmds.busy_clear = 1'b1;
			default:     cmds = '0;
		endcase
	end

	// ==================================================
	// one-tick request pulses
	// ==================================================
	// write pulse follows the sequencer done state, not the command level
	assign lvl_src = {page_done, cmds.read, cmds.erase, cmds.en4b};

	always_ff @(posedge clock_rd2) begin
		if (reset) begin
			lvl_q  <= '0;
			lvl_qq <= '0;
		end else begin
			lvl_q  <= lvl_src;
			lvl_qq <= lvl_q;
		end
	end

	// rising edge one tick after the level
	assign pulse = lvl_q & ~lvl_qq;

	always_comb begin
		flash_req = '0;
		flash_req.read         = pulse[P_READ];
		flash_req.write        = pulse[P_WRITE];
		flash_req.sector_erase = pulse[P_ERASE];
		flash_req.en4b_addr    = pulse[P_EN4B];
		flash_req.shift_bytes  = shift_level;
		// generic write enable rides along every write-type pulse
		flash_req.wren = pulse[P_WRITE] | pulse[P_ERASE] | pulse[P_EN4B] | shift_level;
		flash_req.rden = read_en;
		// datain is filled in at the top from the write sequencer
		flash_req.addr = addr_q;
	end

	// ==================================================
	// busy edge latches
	// ==================================================
	always_ff @(posedge clock_rd2) begin
		if (reset) begin
			busy_q  <= 1'b0;
			busy_qq <= 1'b0;
			busy_re <= 1'b0;
			busy_fe <= 1'b0;
		end else begin
			busy_q  <= flash_rsp.busy;
			busy_qq <= busy_q;
			// clear wins over a new edge
			if (cmds.busy_clear) begin
				busy_re <= 1'b0;
				busy_fe <= 1'b0;
			end else begin
				busy_re <= busy_re | (busy_q & ~busy_qq);
				busy_fe <= busy_fe | (~busy_q & busy_qq);
			end
		end
	end

	// status, one register stage
	always_ff @(posedge clock_rd2) begin
		if (reset) begin
			status_word <= '0;
		end else begin
			status_word.staged_byte   <= staged_byte;
			status_word.reserved      <= '0;
			status_word.load_en       <= cmds.load;
			status_word.read_en       <= read_en;
			status_word.busy_fe       <= busy_fe;
			status_word.busy_re       <= busy_re;
			status_word.illegal_erase <= flash_rsp.illegal_erase;
			status_word.illegal_write <= flash_rsp.illegal_write;
			status_word.data_valid    <= flash_rsp.data_valid;
			status_word.busy          <= busy_q;
		end
	end

endmodule

`default_nettype wire

// File: read_path/read_capture.sv
// last index is taken from data word bits 7:0, count stops one past it
`timescale 1ns/1ns
`default_nettype none

module read_capture #(
	parameter int BUF_ADDR_W = 8
) (
	input  wire logic                                   clock_rd2,
	input  wire logic                                   reset,
	input  wire host_reg_pkg::cmd_flags_t               cmds,
	input  wire host_reg_pkg::data_word_u               data_word,
	input  wire flash_if_pkg::flash_rsp_t               flash_rsp,
	input  wire logic [BUF_ADDR_W-1:0]                  host_addr,
	output logic                                        read_en,
	output logic [flash_if_pkg::FLASH_BYTE_W-1:0]       rd_byte
);
	import flash_if_pkg::*;

	// one extra bit so a full buffer does not wrap back to zero
	logic [BUF_ADDR_W:0]     count;
	logic [BUF_ADDR_W-1:0]   last_idx;
	logic                    last_dv;
	logic                    store;
	logic [FLASH_BYTE_W-1:0] byte_fmt;

	assign last_idx = data_word.rd.last_index[BUF_ADDR_W-1:0];

	// ==================================================
	// byte counter
	// ==================================================
	// held at zero whenever the read command is not active
	always_ff @(posedge clock_rd2) begin
		if (reset || !cmds.read) begin
			count   <= '0;
			last_dv <= 1'b0;
		end else begin
			// advance on the falling edge of data_valid
			if (last_dv && !flash_rsp.data_valid && read_en) begin
				count <= count + 1'b1;
			end
			last_dv <= flash_rsp.data_valid;
		end
	end

	// rden to the controller, drops once the last index is stored
	assign read_en = cmds.read && (count <= {1'b0, last_idx});

	assign store    = read_en & flash_rsp.data_valid;
	assign byte_fmt = bit_rev(flash_rsp.dataout);

	// port a fills from the flash, port b serves the host
	byte_buffer #(
		.ADDR_W (BUF_ADDR_W)
	) u_rd_buf (
		.clock_rd2 (clock_rd2),
		.a_addr    (count[BUF_ADDR_W-1:0]),
		.a_din     (byte_fmt),
		.a_we      (store),
		.a_dout    (),
		.b_addr    (host_addr),
		.b_dout    (rd_byte)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the flash bridge testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module tb_flash_bridge \
	-o sim_flash_bridge &&
./obj_dir/sim_flash_bridge | tee /dev/stderr | grep -qxF '** PASS **' &&
echo "simulation passed" ||
{
	echo "simulation failed"
	exit 1
}

// File: tb/flash_bridge_assertions.sv
// bound into flash_bridge_top, sampled on clock_rd2, checks skipped while reset is high
`timescale 1ns/1ns
`default_nettype none

module flash_bridge_assertions (
	input wire logic                     clock_rd2,
	input wire logic                     reset,
	input wire flash_if_pkg::flash_req_t flash_req,
	input wire host_reg_pkg::status_t    status_word
);

	// assertion failure count
	int fail_count = 0;

	// ==================================================
	// reset state
	// ==================================================
	a_reset_clear: assert property (@(posedge clock_rd2)
		reset |=> (!flash_req.read && !flash_req.write && !flash_req.sector_erase &&
			!flash_req.en4b_addr && !flash_req.wren && !flash_req.shift_bytes &&
			!flash_req.rden && status_word == '0))
		else begin
			$error("request pulses or status not cleared by reset");
			fail_count++;
		end

	// ==================================================
	// request pulses
	// ==================================================
	// wren only alongside a write-type pulse
	a_wren_rule: assert property (@(posedge clock_rd2) disable iff (reset)
		flash_req.wren == (flash_req.write | flash_req.sector_erase |
			flash_req.en4b_addr | flash_req.shift_bytes))
		else begin
			$error("wren does not match the write-type pulses");
			fail_count++;
		end

	// each pulse is one tick wide
	a_read_tick: assert property (@(posedge clock_rd2) disable iff (reset)
		flash_req.read |=> !flash_req.read)
		else begin
			$error("read pulse longer than one tick");
			fail_count++;
		end
	a_erase_tick: assert property (@(posedge clock_rd2) disable iff (reset)
		flash_req.sector_erase |=> !flash_req.sector_erase)
		else begin
			$error("sector_erase pulse longer than one tick");
			fail_count++;
		end
	a_en4b_tick: assert property (@(posedge clock_rd2) disable iff (reset)
		flash_req.en4b_addr |=> !flash_req.en4b_addr)
		else begin
			$error("en4b_addr pulse longer than one tick");
			fail_count++;
		end
	a_write_tick: assert property (@(posedge clock_rd2) disable iff (reset)
		flash_req.write |=> !flash_req.write)
		else begin
			$error("write pulse longer than one tick");
			fail_count++;
		end
	a_shift_tick: assert property (@(posedge clock_rd2) disable iff (reset)
		flash_req.shift_bytes |=> !flash_req.shift_bytes)
		else begin
			$error("shift_bytes pulse longer than one tick");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: tb/tb_flash_bridge.sv
// flash controller model serves reads only, busy stays low outside a read, one page per run
`timescale 1ns/1ns
`default_nettype none

module tb_flash_bridge;
	import host_reg_pkg::*;
	import flash_if_pkg::*;

	localparam int BUF_ADDR_W = 8;
	localparam int PAGE_BYTES = 128;
	localparam int LAST_INDEX = 19;
	// five tests, each allowed a full page plus margin
	localparam int TEST_CYCLES = 3 * PAGE_BYTES + 200;
	localparam int WATCHDOG_NS = 5 * TEST_CYCLES * 4;

	logic        clock_rd2;
	logic        reset;
	logic [31:0] cntlr_word;
	logic [31:0] addr_word;
	logic [31:0] data_word;
	logic        host_we;
	status_t     status_word;
	logic [7:0]  rd_byte;
	flash_req_t  flash_req;
	flash_rsp_t  flash_rsp;

	// flash response pieces, model side and tb side
	logic       rsp_busy;
	logic       rsp_valid;
	logic [7:0] rsp_dataout;
	logic       ill_write;
	logic       ill_erase;

	integer     seed;
	logic [7:0] page_bytes [PAGE_BYTES];
	logic [7:0] raw_bytes [256];
	logic [7:0] shift_log [$];
	int         read_count = 0;
	int         erase_count = 0;
	int         en4b_count = 0;
	int         write_count = 0;
	int         r0;
	int         w0;
	int         s0;

	assign flash_rsp = '{
		dataout:       rsp_dataout,
		busy:          rsp_busy,
		data_valid:    rsp_valid,
		illegal_write: ill_write,
		illegal_erase: ill_erase
	};

	flash_bridge_top #(
		.BUF_ADDR_W (BUF_ADDR_W),
		.PAGE_BYTES (PAGE_BYTES)
	) DUT (
		.clock_rd2   (clock_rd2),
		.reset       (reset),
		.cntlr_word  (cntlr_word),
		.addr_word   (addr_word),
		.data_word   (data_word),
		.host_we     (host_we),
		.status_word (status_word),
		.rd_byte     (rd_byte),
		.flash_req   (flash_req),
		.flash_rsp   (flash_rsp)
	);

	bind flash_bridge_top flash_bridge_assertions u_protocol_checks (
		.clock_rd2   (clock_rd2),
		.reset       (reset),
		.flash_req   (flash_req),
		.status_word (status_word)
	);

	initial begin
		clock_rd2 = 1'b0;
	end

	always #2 clock_rd2 = ~clock_rd2;

	// ==================================================
	// helpers
	// ==================================================
	function automatic logic [7:0] reverse_bits(input logic [7:0] b);
		logic [7:0] r;
		for (int j = 0; j < 8; j++) begin
			r[j] = b[7 - j];
		end
		return r;
	endfunction

	task automatic flag_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("** FAIL **");
		$fatal(1, "stopping on first mismatch");
	endtask

	// n rising edges, then sample at the falling edge
	task automatic settle(input int n);
		repeat (n) @(posedge clock_rd2);
		@(negedge clock_rd2);
	endtask

	// opcode needs two ticks to reach the decode
	task automatic issue_opcode(input logic [7:0] op);
		@(posedge clock_rd2);
		cntlr_word <= {24'h0, op};
		repeat (3) @(posedge clock_rd2);
	endtask

	task automatic hold_opcode(input logic [7:0] op, input int cycles);
		issue_opcode(op);
		repeat (cycles) @(posedge clock_rd2);
		issue_opcode(8'h00);
		settle(2);
	endtask

	// one strobe per byte, rising edge of host_we does the write
	task automatic load_byte(input logic [7:0] a, input logic [7:0] b);
		@(posedge clock_rd2);
		data_word <= {16'h0, a, b};
		host_we   <= 1'b1;
		@(posedge clock_rd2);
		host_we   <= 1'b0;
	endtask

	// ==================================================
	// flash controller model
	// ==================================================
	// one data_valid tick and two idle ticks per byte, until rden drops
	task automatic serve_read();
		int i;
		i = 0;
		@(posedge clock_rd2);
		rsp_busy <= 1'b1;
		@(negedge clock_rd2);
		while (flash_req.rden) begin
			@(posedge clock_rd2);
			rsp_valid   <= 1'b1;
			rsp_dataout <= raw_bytes[i];
			@(posedge clock_rd2);
			rsp_valid   <= 1'b0;
			@(posedge clock_rd2);
			i++;
			@(negedge clock_rd2);
		end
		@(posedge clock_rd2);
		rsp_busy <= 1'b0;
	endtask

	initial begin
		rsp_busy    = 1'b0;
		rsp_valid   = 1'b0;
		rsp_dataout = 8'h00;
		forever begin
			@(negedge clock_rd2);
			if (flash_req.read) begin
				serve_read();
			end
		end
	end

	// pulse counters and shifted data, sampled mid cycle
	always @(negedge clock_rd2) begin
		if (flash_req.shift_bytes) begin
			shift_log.push_back(flash_req.datain);
		end
		if (flash_req.read) read_count++;
		if (flash_req.sector_erase) erase_count++;
		if (flash_req.en4b_addr) en4b_count++;
		if (flash_req.write) write_count++;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		reset      = 1'b1;
		cntlr_word = '0;
		addr_word  = '0;
		data_word  = '0;
		host_we    = 1'b0;
		ill_write  = 1'b0;
		ill_erase  = 1'b0;
		seed       = 32'hd45a_79b3;
		for (int k = 0; k < PAGE_BYTES; k++) begin
			page_bytes[k] = 8'($random(seed));
		end
		for (int k = 0; k < 256; k++) begin
			raw_bytes[k] = 8'($random(seed));
		end

		repeat (4) @(posedge clock_rd2);
		reset <= 1'b0;
		@(negedge clock_rd2);

		// after reset
		assert ({flash_req.read, flash_req.write, flash_req.sector_erase, flash_req.en4b_addr,
			flash_req.wren, flash_req.shift_bytes, flash_req.rden} == 7'b0)
			else flag_mismatch("request pulse or rden high after reset");
		assert (status_word == '0)
			else flag_mismatch($sformatf("status %h after reset", status_word));

		// erase and en4b pulses, two issues each, held ten ticks
		hold_opcode(FLASH_ERASE, 10);
		hold_opcode(FLASH_ERASE, 10);
		hold_opcode(FLASH_EN4B, 10);
		hold_opcode(FLASH_EN4B, 10);
		assert (erase_count == 2)
			else flag_mismatch($sformatf("%0d erase pulses, expected 2", erase_count));
		assert (en4b_count == 2)
			else flag_mismatch($sformatf("%0d en4b pulses, expected 2", en4b_count));
		assert (read_count == 0 && write_count == 0)
			else flag_mismatch("read or write pulse without a command");

		// load one page into the staging buffer
		issue_opcode(BUF_LOAD);
		for (int k = 0; k < PAGE_BYTES; k++) begin
			load_byte(8'(k), page_bytes[k]);
		end
		for (int k = 0; k < PAGE_BYTES; k += 37) begin
			@(posedge clock_rd2);
			data_word <= {16'h0, 8'(k), 8'h00};
			settle(3);
			assert (status_word.staged_byte == page_bytes[k])
				else flag_mismatch($sformatf("staged byte %h at %0d, expected %h",
					status_word.staged_byte, k, page_bytes[k]));
		end
		issue_opcode(8'h00);

		// page shift-out
		w0 = write_count;
		s0 = shift_log.size();
		issue_opcode(FLASH_WRITE);
		while (write_count == w0) @(negedge clock_rd2);
		settle(10);
		assert (write_count == w0 + 1)
			else flag_mismatch($sformatf("%0d write pulses, expected 1", write_count - w0));
		assert (shift_log.size() - s0 == PAGE_BYTES)
			else flag_mismatch($sformatf("%0d shift pulses, expected %0d",
				shift_log.size() - s0, PAGE_BYTES));
		for (int k = 0; k < PAGE_BYTES; k++) begin
			assert (shift_log[s0 + k] == reverse_bits(page_bytes[k]))
				else flag_mismatch($sformatf("datain %h for byte %0d, expected %h",
					shift_log[s0 + k], k, reverse_bits(page_bytes[k])));
		end
		issue_opcode(8'h00);

		// read collection up to LAST_INDEX
		@(posedge clock_rd2);
		data_word <= 32'(LAST_INDEX);
		r0 = read_count;
		issue_opcode(FLASH_READ);
		while (read_count == r0) @(negedge clock_rd2);
		while (flash_req.rden) @(negedge clock_rd2);
		settle(10);
		assert (read_count == r0 + 1)
			else flag_mismatch($sformatf("%0d read pulses, expected 1", read_count - r0));
		assert (status_word.read_en == 1'b0)
			else flag_mismatch("read_en still high after the last index");
		for (int a = 0; a <= LAST_INDEX; a++) begin
			@(posedge clock_rd2);
			addr_word <= 32'(a);
			settle(1);
			assert (rd_byte == reverse_bits(raw_bytes[a]))
				else flag_mismatch($sformatf("rd_byte %h at %0d, expected %h",
					rd_byte, a, reverse_bits(raw_bytes[a])));
			// flash address is addr_word one tick later
			assert (flash_req.addr == 32'(a))
				else flag_mismatch($sformatf("flash addr %h, expected %h",
					flash_req.addr, 32'(a)));
		end
		issue_opcode(8'h00);

		// busy edges from the read stay latched
		settle(6);
		assert (status_word.busy_re && status_word.busy_fe)
			else flag_mismatch("busy edges not latched after a busy pulse");
		hold_opcode(BUSY_CLEAR, 4);
		settle(2);
		assert (!status_word.busy_re && !status_word.busy_fe)
			else flag_mismatch("busy edges not cleared by BUSY_CLEAR");

		// illegal flags follow the model levels
		@(posedge clock_rd2);
		ill_write <= 1'b1;
		settle(2);
		assert (status_word.illegal_write && !status_word.illegal_erase)
			else flag_mismatch("illegal_write not reflected in status");
		@(posedge clock_rd2);
		ill_write <= 1'b0;
		ill_erase <= 1'b1;
		settle(2);
		assert (!status_word.illegal_write && status_word.illegal_erase)
			else flag_mismatch("illegal_erase not reflected in status");

		if (DUT.u_protocol_checks.fail_count != 0) begin
			$display("protocol assertions failed %0d times", DUT.u_protocol_checks.fail_count);
			$display("** FAIL **");
			$fatal(1, "protocol assertion failure");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
common/host_reg_pkg.sv
common/flash_if_pkg.sv
hdl/byte_buffer.sv
hdl/flash_control.sv
read_path/read_capture.sv
write_path/write_sequencer.sv
hdl/flash_bridge_top.sv
tb/flash_bridge_assertions.sv
tb/tb_flash_bridge.sv

// File: write_path/write_sequencer.sv
// page length is fixed, flash busy is not watched and there is no back-pressure
`timescale 1ns/1ns
`default_nettype none

module write_sequencer #(
	parameter int BUF_ADDR_W = 8,
	parameter int PAGE_BYTES = 128
) (
	input  wire logic                                   clock_rd2,
	input  wire logic                                   reset,
	input  wire host_reg_pkg::cmd_flags_t               cmds,
	input  wire host_reg_pkg::data_word_u               data_word,
	input  wire logic                                   host_we,
	output logic [flash_if_pkg::FLASH_BYTE_W-1:0]       datain,
	output logic                                        shift_level,
	output logic                                        page_done,
	output logic [flash_if_pkg::FLASH_BYTE_W-1:0]       staged_byte
);
	import flash_if_pkg::*;

	localparam logic [BUF_ADDR_W-1:0] LAST_BYTE = BUF_ADDR_W'(PAGE_BYTES - 1);

	typedef enum logic [1:0] {
		ST_SETTLE,
		ST_SHIFT,
		ST_ADVANCE,
		ST_DONE
	} state_e;

	state_e                  state;
	logic [BUF_ADDR_W-1:0]   byte_cnt;
	logic                    we_q;
	logic                    load_wr;
	logic [FLASH_BYTE_W-1:0] page_byte;

	// ==================================================
	// host byte loading
	// ==================================================
	always_ff @(posedge clock_rd2) begin
		if (reset) begin
			we_q <= 1'b0;
		end else begin
			we_q <= host_we;
		end
	end

	// strobe edge, only while BUF_LOAD is decoded
	assign load_wr = cmds.load & host_we & ~we_q;

	byte_buffer #(
		.ADDR_W (BUF_ADDR_W)
	) u_wr_buf (
		.clock_rd2 (clock_rd2),
		.a_addr    (data_word.ld.load_addr[BUF_ADDR_W-1:0]),
		.a_din     (data_word.ld.load_byte),
		.a_we      (load_wr),
		.a_dout    (staged_byte),
		.b_addr    (byte_cnt),
		.b_dout    (page_byte)
	);

	// ==================================================
	// page shift-out, three ticks per byte
	// ==================================================
	always_ff @(posedge clock_rd2) begin
		if (reset || !cmds.write) begin
			state    <= ST_SETTLE;
			byte_cnt <= '0;
		end else begin
			case (state)
				// buffer read of byte_cnt lands during shift
				ST_SETTLE: state <= ST_SHIFT;
				ST_SHIFT:  state <= ST_ADVANCE;
				ST_ADVANCE: begin
					if (byte_cnt == LAST_BYTE) begin
						state <= ST_DONE;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
						state    <= ST_SETTLE;
					end
				end
				// wait here until the host drops the opcode
				default: state <= ST_DONE;
			endcase
		end
	end

	assign shift_level = (state == ST_SHIFT);
	assign page_done   = (state == ST_DONE);
	assign datain      = bit_rev(page_byte);

endmodule

`default_nettype wire
